/* Makefile */
SIM      := verilator
TOP      := dcache_tb
FILELIST := list.f
FLAGS    := --binary --timing --assert -Wno-fatal -j 0
OBJDIR   := obj_dir
BIN      := $(OBJDIR)/V$(TOP)
LOG      := sim.log
SRCS     := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* hdl/burst_mem.sv */
module burst_mem #(
	parameter int MEM_WORDS = 2048,
	parameter int READ_LATENCY = 3
) (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             ar_valid,
	input  logic [dcache_pkg::ADDR_W-1:0]    ar_addr,
	output logic                             ar_ready,
	output logic                             r_valid,
	output logic [dcache_pkg::BEAT_W-1:0]    r_data,
	output logic                             r_last,
	input  logic                             wr_en,
	input  logic [dcache_pkg::ADDR_W-1:0]    wr_addr,
	input  logic [dcache_pkg::DATA_W-1:0]    wr_data,
	input  logic [dcache_pkg::STRB_W-1:0]    wr_strb
);

	localparam int WORD_AW = $clog2(MEM_WORDS);
	localparam int WORD_OFF = $clog2(dcache_pkg::BEAT_W / 8);
	localparam int WORD_BYTES = dcache_pkg::BEAT_W / 8;
	localparam int HALF_W = dcache_pkg::BEAT_W / 2;
	localparam int CNT_W = $clog2(dcache_pkg::BEATS);
	localparam int DLY_W = $clog2(READ_LATENCY + 1);

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_WAIT = 2'd1;
	localparam logic [1:0] ST_BURST = 2'd2;

	logic [dcache_pkg::BEAT_W-1:0] mem [MEM_WORDS];
	logic [1:0] state_q;
	logic [DLY_W-1:0] delay_q;
	logic [CNT_W-1:0] beat_q;
	logic [WORD_AW-CNT_W-1:0] line_q;
	logic [WORD_AW-1:0] wr_base;
	logic emit;

	// word w holds w low and ~w high
	initial begin
		for (int w = 0; w < MEM_WORDS; w++) begin
			mem[w] = {~w[HALF_W-1:0], w[HALF_W-1:0]};
		end
	end

	// addresses above the depth wrap around
	assign wr_base = {wr_addr[WORD_AW+WORD_OFF-1:WORD_OFF+1], 1'b0};

	always @(posedge clk) begin
		if (wr_en) begin
			for (int b = 0; b < dcache_pkg::STRB_W; b++) begin
				if (wr_strb[b]) begin
					mem[wr_base + WORD_AW'(b / WORD_BYTES)][8*(b % WORD_BYTES) +: 8] <=
						wr_data[8*b +: 8];
				end
			end
		end
	end

	assign emit = ((state_q == ST_WAIT) && (delay_q == '0)) || ((state_q == ST_BURST) && !r_last);

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= ST_IDLE;
			ar_ready <= 1'b0;
			r_valid <= 1'b0;
			r_last <= 1'b0;
			delay_q <= '0;
			beat_q <= '0;
		end else begin
			// one cycle of back-pressure per burst
			ar_ready <= (state_q == ST_IDLE) && ar_valid && !ar_ready;
			r_valid <= emit;
			r_last <= emit && (beat_q == CNT_W'(dcache_pkg::BEATS - 1));
			if (emit) begin
				beat_q <= beat_q + 1'b1;
			end
			case (state_q)
				ST_IDLE: begin
					if (ar_valid && ar_ready) begin
						delay_q <= DLY_W'(READ_LATENCY - 1);
						beat_q <= '0;
						state_q <= ST_WAIT;
					end
				end
				ST_WAIT: begin
					if (delay_q == '0) begin
						state_q <= ST_BURST;
					end else begin
						delay_q <= delay_q - 1'b1;
					end
				end
				default: begin
					if (r_last) begin
						state_q <= ST_IDLE;
					end
				end
			endcase
		end
	end

	// line base captured on acceptance
	always_ff @(posedge clk) begin
		if (state_q == ST_IDLE && ar_valid && ar_ready) begin
			line_q <= ar_addr[WORD_AW+WORD_OFF-1:CNT_W+WORD_OFF];
		end
		if (emit) begin
			r_data <= mem[{line_q, beat_q}];
		end
	end

endmodule

/* hdl/dcache.sv */
module dcache (
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                valid,
	output logic                                ready,
	input  logic [dcache_pkg::ADDR_W-1:0]       addr,
	output logic [dcache_pkg::DATA_W-1:0]       dout,
	input  logic                                wren,
	input  logic [dcache_pkg::DATA_W-1:0]       din,
	input  logic [dcache_pkg::STRB_W-1:0]       strb,
	output logic                                ar_valid,
	output logic [dcache_pkg::ADDR_W-1:0]       ar_addr,
	input  logic                                ar_ready,
	input  logic                                r_valid,
	input  logic [dcache_pkg::BEAT_W-1:0]       r_data,
	input  logic                                r_last,
	output logic                                mem_wr_en,
	output logic [dcache_pkg::ADDR_W-1:0]       mem_wr_addr,
	output logic [dcache_pkg::DATA_W-1:0]       mem_wr_data,
	output logic [dcache_pkg::STRB_W-1:0]       mem_wr_strb
);

	localparam int ROW_OFF = $clog2(dcache_pkg::ROW_W / 8);
	localparam int DW_OFF = $clog2(dcache_pkg::DATA_W / 8);
	localparam int ROW_AW = $clog2(dcache_pkg::ROWS);
	localparam int LANES = dcache_pkg::ROW_W / dcache_pkg::BEAT_W;

	logic [dcache_pkg::INDEX_W-1:0] index;
	logic [dcache_pkg::TAG_W-1:0] tag;
	logic [dcache_pkg::WAYS-1:0] hit_way;
	logic [dcache_pkg::WAYS-1:0] hit_way_q;
	logic [dcache_pkg::WAYS-1:0] fill_way;
	logic [ROW_AW-1:0] fill_row;
	logic [ROW_AW-1:0] sram_row;
	logic [LANES-1:0] fill_lane_we;
	logic [dcache_pkg::BEAT_W-1:0] fill_data;
	logic fill_done;
	logic fill_wr;
	logic busy;
	logic req;
	logic rd_hit;
	logic miss;
	logic wr_req;
	logic [dcache_pkg::ROW_W-1:0] way_rdata [dcache_pkg::WAYS];
	logic [dcache_pkg::ROW_W-1:0] line;

	assign index = addr[dcache_pkg::OFFSET_W +: dcache_pkg::INDEX_W];
	assign tag = addr[dcache_pkg::ADDR_W-1 -: dcache_pkg::TAG_W];

	// nothing new is taken while ready is up or a refill runs
	assign req = valid && !ready && !busy;
	assign rd_hit = req && !wren && (|hit_way);
	assign miss = req && !wren && !(|hit_way);
	assign wr_req = req && wren;

	assign fill_wr = |fill_lane_we;
	assign sram_row = busy ? fill_row : addr[ROW_OFF +: ROW_AW];

	// write-through, no allocate
	assign mem_wr_en = wr_req;
	assign mem_wr_addr = addr;
	assign mem_wr_data = din;
	assign mem_wr_strb = strb;

	dcache_tag_array u_tags (
		.clk      (clk),
		.rst      (rst),
		.index    (index),
		.tag      (tag),
		.fill_en  (fill_done),
		.fill_way (fill_way),
		.inval_en (wr_req),
		.hit_way  (hit_way)
	);

	for (genvar w = 0; w < dcache_pkg::WAYS; w++) begin : g_way
		dcache_data_sram u_data (
			.clk       (clk),
			.en        ((rd_hit && hit_way[w]) || (fill_wr && fill_way[w])),
			.we        (fill_wr),
			.lane_we   (fill_lane_we),
			.row       (sram_row),
			.beat_data (fill_data),
			.rdata     (way_rdata[w])
		);
	end

	dcache_refill u_refill (
		.clk          (clk),
		.rst          (rst),
		.miss         (miss),
		.addr         (addr),
		.ar_ready     (ar_ready),
		.r_valid      (r_valid),
		.r_data       (r_data),
		.r_last       (r_last),
		.busy         (busy),
		.ar_valid     (ar_valid),
		.ar_addr      (ar_addr),
		.fill_way     (fill_way),
		.fill_row     (fill_row),
		.fill_lane_we (fill_lane_we),
		.fill_data    (fill_data),
		.fill_done    (fill_done)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			ready <= 1'b0;
		end else begin
			ready <= rd_hit || wr_req;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_hit) begin
			hit_way_q <= hit_way;
		end
	end

	// pick the row of the way that hit, then the doubleword
	always_comb begin
		line = '0;
		for (int w = 0; w < dcache_pkg::WAYS; w++) begin
			if (hit_way_q[w]) begin
				line = way_rdata[w];
			end
		end
	end

	assign dout = line[addr[ROW_OFF-1:DW_OFF]*dcache_pkg::DATA_W +: dcache_pkg::DATA_W];

endmodule

/* hdl/dcache_data_sram.sv */
module dcache_data_sram (
	input  logic                                                    clk,
	input  logic                                                    en,
	input  logic                                                    we,
	input  logic [dcache_pkg::ROW_W/dcache_pkg::BEAT_W-1:0]         lane_we,
	input  logic [$clog2(dcache_pkg::ROWS)-1:0]                     row,
	input  logic [dcache_pkg::BEAT_W-1:0]                           beat_data,
	output logic [dcache_pkg::ROW_W-1:0]                            rdata
);

	localparam int LANES = dcache_pkg::ROW_W / dcache_pkg::BEAT_W;

	logic [dcache_pkg::ROW_W-1:0] mem [dcache_pkg::ROWS];

	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				// one beat lands in its own 32-bit lane
				for (int l = 0; l < LANES; l++) begin
					if (lane_we[l]) begin
						mem[row][l*dcache_pkg::BEAT_W +: dcache_pkg::BEAT_W] <= beat_data;
					end
				end
			end else begin
				rdata <= mem[row];
			end
		end
	end

endmodule

/* hdl/dcache_pkg.sv */
package dcache_pkg;

	// request side
	localparam int ADDR_W = 32;
	localparam int DATA_W = 64;
	localparam int STRB_W = DATA_W / 8;

	// memory beat
	localparam int BEAT_W = 32;

	// cache geometry
	localparam int WAYS = 4;
	localparam int SETS = 16;
	localparam int INDEX_W = 4;
	localparam int TAG_W = 22;
	localparam int BEATS = 16;

	// byte offset within a line, index sits right above it
	localparam int OFFSET_W = ADDR_W - TAG_W - INDEX_W;

	// data sram shape, four beats per row
	localparam int ROW_W = 128;
	localparam int ROWS = 64;

endpackage

/* hdl/dcache_refill.sv */
module dcache_refill (
	input  logic                                               clk,
	input  logic                                               rst,
	input  logic                                               miss,
	input  logic [dcache_pkg::ADDR_W-1:0]                      addr,
	input  logic                                               ar_ready,
	input  logic                                               r_valid,
	input  logic [dcache_pkg::BEAT_W-1:0]                      r_data,
	input  logic                                               r_last,
	output logic                                               busy,
	output logic                                               ar_valid,
	output logic [dcache_pkg::ADDR_W-1:0]                      ar_addr,
	output logic [dcache_pkg::WAYS-1:0]                        fill_way,
	output logic [$clog2(dcache_pkg::ROWS)-1:0]                fill_row,
	output logic [dcache_pkg::ROW_W/dcache_pkg::BEAT_W-1:0]    fill_lane_we,
	output logic [dcache_pkg::BEAT_W-1:0]                      fill_data,
	output logic                                               fill_done
);

	localparam int LANES = dcache_pkg::ROW_W / dcache_pkg::BEAT_W;
	localparam int LANE_W = $clog2(LANES);
	localparam int CNT_W = $clog2(dcache_pkg::BEATS);

	localparam logic ST_IDLE = 1'b0;
	localparam logic ST_REFILL = 1'b1;

	logic state_q;
	logic [CNT_W-1:0] beat_q;
	logic [dcache_pkg::WAYS-1:0] victim_q;
	logic beat_in;

	// burst goes out as soon as the miss is seen
	assign ar_valid = (state_q == ST_IDLE) && miss;
	assign ar_addr = {addr[dcache_pkg::ADDR_W-1:dcache_pkg::OFFSET_W],
		{dcache_pkg::OFFSET_W{1'b0}}};

	assign busy = (state_q == ST_REFILL);
	assign beat_in = busy && r_valid;

	// beat count splits into row select and lane
	assign fill_way = victim_q;
	assign fill_row = {addr[dcache_pkg::OFFSET_W +: dcache_pkg::INDEX_W], beat_q[CNT_W-1:LANE_W]};
	assign fill_data = r_data;
	assign fill_done = beat_in && r_last;

	always_comb begin
		fill_lane_we = '0;
		if (beat_in) begin
			fill_lane_we[beat_q[LANE_W-1:0]] = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= ST_IDLE;
			beat_q <= '0;
			victim_q <= {{(dcache_pkg::WAYS-1){1'b0}}, 1'b1};
		end else begin
			case (state_q)
				ST_IDLE: begin
					// victim keeps rotating until a refill starts
					victim_q <= {victim_q[dcache_pkg::WAYS-2:0], victim_q[dcache_pkg::WAYS-1]};
					beat_q <= '0;
					if (ar_valid && ar_ready) begin
						state_q <= ST_REFILL;
					end
				end
				default: begin
					if (r_valid) begin
						beat_q <= beat_q + 1'b1;
						if (r_last) begin
							state_q <= ST_IDLE;
						end
					end
				end
			endcase
		end
	end

endmodule

/* hdl/dcache_tag_array.sv */
module dcache_tag_array (
	input  logic                             clk,
	input  logic                             rst,
	input  logic [dcache_pkg::INDEX_W-1:0]   index,
	input  logic [dcache_pkg::TAG_W-1:0]     tag,
	input  logic                             fill_en,
	input  logic [dcache_pkg::WAYS-1:0]      fill_way,
	input  logic                             inval_en,
	output logic [dcache_pkg::WAYS-1:0]      hit_way
);

	logic [dcache_pkg::TAG_W-1:0] tags [dcache_pkg::WAYS][dcache_pkg::SETS];
	logic [dcache_pkg::SETS-1:0] valid_q [dcache_pkg::WAYS];
	logic [dcache_pkg::WAYS-1:0] tag_match;

	// compare all ways in parallel
	always_comb begin
		for (int w = 0; w < dcache_pkg::WAYS; w++) begin
			tag_match[w] = (tags[w][index] == tag);
			hit_way[w] = valid_q[w][index] && tag_match[w];
		end
	end

	// tag storage, written only on a fill
	always_ff @(posedge clk) begin
		for (int w = 0; w < dcache_pkg::WAYS; w++) begin
			if (fill_en && fill_way[w]) begin
				tags[w][index] <= tag;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < dcache_pkg::WAYS; w++) begin
				valid_q[w] <= '0;
			end
		end else begin
			for (int w = 0; w < dcache_pkg::WAYS; w++) begin
				if (fill_en && fill_way[w]) begin
					valid_q[w][index] <= 1'b1;
				end
				// write-through: drop any copy of the written line
				if (inval_en && tag_match[w]) begin
					valid_q[w][index] <= 1'b0;
				end
			end
		end
	end

endmodule

/* hdl/dcache_top.sv */
module dcache_top #(
	parameter int MEM_WORDS = 2048,
	parameter int READ_LATENCY = 3
) (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             valid,
	output logic                             ready,
	input  logic [dcache_pkg::ADDR_W-1:0]    addr,
	output logic [dcache_pkg::DATA_W-1:0]    dout,
	input  logic                             wren,
	input  logic [dcache_pkg::DATA_W-1:0]    din,
	input  logic [dcache_pkg::STRB_W-1:0]    strb
);

	// read channel
	logic ar_valid;
	logic ar_ready;
	logic [dcache_pkg::ADDR_W-1:0] ar_addr;
	logic r_valid;
	logic r_last;
	logic [dcache_pkg::BEAT_W-1:0] r_data;

	// write port
	logic mem_wr_en;
	logic [dcache_pkg::ADDR_W-1:0] mem_wr_addr;
	logic [dcache_pkg::DATA_W-1:0] mem_wr_data;
	logic [dcache_pkg::STRB_W-1:0] mem_wr_strb;

	dcache u_dcache (
		.clk         (clk),
		.rst         (rst),
		.valid       (valid),
		.ready       (ready),
		.addr        (addr),
		.dout        (dout),
		.wren        (wren),
		.din         (din),
		.strb        (strb),
		.ar_valid    (ar_valid),
		.ar_addr     (ar_addr),
		.ar_ready    (ar_ready),
		.r_valid     (r_valid),
		.r_data      (r_data),
		.r_last      (r_last),
		.mem_wr_en   (mem_wr_en),
		.mem_wr_addr (mem_wr_addr),
		.mem_wr_data (mem_wr_data),
		.mem_wr_strb (mem_wr_strb)
	);

	burst_mem #(
		.MEM_WORDS    (MEM_WORDS),
		.READ_LATENCY (READ_LATENCY)
	) u_mem (
		.clk      (clk),
		.rst      (rst),
		.ar_valid (ar_valid),
		.ar_addr  (ar_addr),
		.ar_ready (ar_ready),
		.r_valid  (r_valid),
		.r_data   (r_data),
		.r_last   (r_last),
		.wr_en    (mem_wr_en),
		.wr_addr  (mem_wr_addr),
		.wr_data  (mem_wr_data),
		.wr_strb  (mem_wr_strb)
	);

endmodule

/* list.f */
hdl/dcache_pkg.sv
hdl/dcache_tag_array.sv
hdl/dcache_data_sram.sv
hdl/dcache_refill.sv
hdl/dcache.sv
hdl/burst_mem.sv
hdl/dcache_top.sv
verif/dcache_tb.sv

/* verif/dcache_tb.sv */
module dcache_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int MEM_WORDS = 2048;
	localparam int READ_LATENCY = 3;

	// requests issued by each phase
	localparam int N_PAIRS = 20;
	localparam int N_MERGE = 20;
	localparam int N_RANDOM = 300;
	localparam int N_REQ = 2 * N_PAIRS + 3 * N_MERGE + N_RANDOM;
	// a read miss takes READ_LATENCY + 20 cycles, ready cycle included
	localparam int MISS_MAX = READ_LATENCY + 24;
	localparam int LIMIT = N_REQ * MISS_MAX + 100;

	logic clk;
	logic rst;
	logic valid;
	logic ready;
	logic [dcache_pkg::ADDR_W-1:0] addr;
	logic [dcache_pkg::DATA_W-1:0] dout;
	logic wren;
	logic [dcache_pkg::DATA_W-1:0] din;
	logic [dcache_pkg::STRB_W-1:0] strb;

	logic [31:0] lfsr;
	logic [31:0] model [MEM_WORDS];
	int cycles;

	dcache_top #(
		.MEM_WORDS    (MEM_WORDS),
		.READ_LATENCY (READ_LATENCY)
	) dut0 (
		.clk   (clk),
		.rst   (rst),
		.valid (valid),
		.ready (ready),
		.addr  (addr),
		.dout  (dout),
		.wren  (wren),
		.din   (din),
		.strb  (strb)
	);

	always #50 clk = ~clk;

	task automatic abort_run();
		$display("Verification failed");
		$fatal(1);
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT) begin
			$display("Timeout: test did not finish within %0d cycles", LIMIT);
			abort_run();
		end
	end

	// galois lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0]) begin
			n = n ^ 32'h80200003;
		end
		return n;
	endfunction

	// one lfsr step per bit
	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			r = {r[62:0], lfsr[0]};
		end
		return r;
	endfunction

	// doubleword aligned, inside an 8 KiB window
	function automatic logic [31:0] rand_addr();
		logic [63:0] r;
		r = rand_bits(10);
		return {19'd0, r[9:0], 3'b000};
	endfunction

	function automatic int word_index(input logic [31:0] a);
		return int'((a >> 2) % MEM_WORDS);
	endfunction

	function automatic logic [63:0] expected_dw(input logic [31:0] a);
		int wi;
		wi = word_index(a);
		return {model[wi + 1], model[wi]};
	endfunction

	function automatic void apply_write(input logic [31:0] a, input logic [63:0] d,
			input logic [7:0] s);
		int wi;
		wi = word_index(a);
		for (int b = 0; b < 8; b++) begin
			if (s[b]) begin
				model[wi + b / 4][8 * (b % 4) +: 8] = d[8 * b +: 8];
			end
		end
	endfunction

	task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
		assert (got === exp) else begin
			$display("Error: %s is %h, expected %h", name, got, exp);
			abort_run();
		end
	endtask

	// lat counts rising edges from the drive edge to the one that raised ready
	task automatic request(input logic w, input logic [31:0] a, input logic [63:0] d,
			input logic [7:0] s, output int lat, output logic [63:0] rdata);
		@(posedge clk);
		valid <= 1'b1;
		wren <= w;
		addr <= a;
		din <= d;
		strb <= s;
		lat = 0;
		@(negedge clk);
		while (!ready) begin
			@(posedge clk);
			lat++;
			@(negedge clk);
		end
		rdata = dout;
		assert (lat >= 1) else begin
			$display("ready was already high in the cycle the request was driven");
			abort_run();
		end
	endtask

	task automatic read_and_check(input logic [31:0] a, output int lat,
			output logic [63:0] data);
		request(1'b0, a, 64'd0, 8'd0, lat, data);
		compare("dout", data, expected_dw(a));
	endtask

	task automatic write_and_check(input logic [31:0] a, input logic [63:0] d,
			input logic [7:0] s);
		int lat;
		logic [63:0] unused;
		request(1'b1, a, d, s, lat, unused);
		apply_write(a, d, s);
		compare("ready latency", 64'(lat), 64'd1);
	endtask

	initial begin
		logic [31:0] a;
		logic [63:0] first;
		logic [63:0] second;
		logic [63:0] d;
		logic [7:0] s;
		logic [1:0] op;
		int lat;

		clk = 1'b0;
		rst = 1'b1;
		valid = 1'b0;
		wren = 1'b0;
		addr = '0;
		din = '0;
		strb = '0;
		cycles = 0;
		lfsr = 32'd15;
		// same start pattern as the memory: w low, ~w high
		for (int w = 0; w < MEM_WORDS; w++) begin
			model[w] = {~16'(w), 16'(w)};
		end

		// last pass is the first cycle out of reset
		for (int i = 0; i < 5; i++) begin
			@(posedge clk);
			// a write with no strobes waits across reset
			if (i == 0) begin
				valid <= 1'b1;
				wren <= 1'b1;
			end
			if (i == 4) begin
				rst <= 1'b0;
			end
			@(negedge clk);
			compare("ready", 64'(ready), 64'd0);
		end
		// the held write is taken at the first edge out of reset
		@(negedge clk);
		compare("ready", 64'(ready), 64'd1);

		// a repeated read must hit
		for (int i = 0; i < N_PAIRS; i++) begin
			a = rand_addr();
			read_and_check(a, lat, first);
			read_and_check(a, lat, second);
			compare("ready latency", 64'(lat), 64'd1);
		end

		// cache the line, write through it, read the merged value back
		for (int i = 0; i < N_MERGE; i++) begin
			a = rand_addr();
			read_and_check(a, lat, first);
			d = rand_bits(64);
			s = 8'(rand_bits(8));
			write_and_check(a, d, s);
			read_and_check(a, lat, second);
		end

		// mixed traffic, about one write in four
		for (int i = 0; i < N_RANDOM; i++) begin
			a = rand_addr();
			op = 2'(rand_bits(2));
			if (op == 2'd0) begin
				d = rand_bits(64);
				s = 8'(rand_bits(8));
				write_and_check(a, d, s);
			end else begin
				read_and_check(a, lat, first);
			end
		end

		@(posedge clk);
		valid <= 1'b0;
		repeat (2) @(posedge clk);
		$display("Verification passed");
		$finish;
	end

endmodule
